// File: logic/pcm_pkg.sv
// pcm player package with register map, prescaler mode and channel state enums, width constants
package pcm_pkg;

    // rom address, prescaler and raw sample widths
    localparam int rom_aw = 17;
    localparam int pre_w  = 12;
    localparam int smp_w  = 7;

    // host register slots
    typedef enum logic [3:0] {
        reg_a_pre_lo   = 4'd0,
        reg_a_pre_hi   = 4'd1,
        reg_a_addr_lo  = 4'd2,
        reg_a_addr_mid = 4'd3,
        reg_a_addr_hi  = 4'd4,
        reg_a_play     = 4'd5,
        reg_b_pre_lo   = 4'd6,
        reg_b_pre_hi   = 4'd7,
        reg_b_addr_lo  = 4'd8,
        reg_b_addr_mid = 4'd9,
        reg_b_addr_hi  = 4'd10,
        reg_b_play     = 4'd11,
        reg_gain       = 4'd12,
        reg_loop       = 4'd13
    } reg_addr_e;

    // prescaler mode, bits 5:4 of pre_hi
    // value 3 is decoded like pre_low8
    typedef enum logic [1:0] {
        pre_full   = 2'd0,
        pre_low8   = 2'd1,
        pre_nibble = 2'd2
    } pre_mode_e;

    typedef enum logic {
        ch_idle = 1'b0,
        ch_play = 1'b1
    } ch_state_e;

endpackage

// File: logic/pcm_regs.sv
// host register file with address decode, load and play strobes, per-channel field slicing
`timescale 1ns/1ps

module pcm_regs #(
    parameter bit inv_a0    = 1'b0,
    parameter bit gain_a_hi = 1'b1
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [3:0]                  addr,
    input  logic [7:0]                  din,
    input  logic                        cs,
    input  logic                        wr_n,
    output logic [pcm_pkg::rom_aw-1:0]  a_start,
    output logic [pcm_pkg::rom_aw-1:0]  b_start,
    output logic [pcm_pkg::pre_w-1:0]   a_pre,
    output logic [pcm_pkg::pre_w-1:0]   b_pre,
    output pcm_pkg::pre_mode_e          a_mode,
    output pcm_pkg::pre_mode_e          b_mode,
    output logic                        a_loop,
    output logic                        b_loop,
    output logic                        a_load,
    output logic                        b_load,
    output logic                        a_play,
    output logic                        b_play,
    output logic [3:0]                  gain_a,
    output logic [3:0]                  gain_b
);
    import pcm_pkg::*;

    // 14 byte registers, not every bit is used
    logic [7:0] regs [0:13];
    reg_addr_e  addr_j;
    logic       wr_en;

    // some boards swap the lsb of the host address
    assign addr_j = reg_addr_e'(inv_a0 ? (addr ^ 4'b0001) : addr);
    assign wr_en  = cs && !wr_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 14; i++) begin
                regs[i] <= 8'd0;
            end
            a_load <= 1'b0;
            b_load <= 1'b0;
            a_play <= 1'b0;
            b_play <= 1'b0;
        end else begin
            // slots 14 and 15 are not backed
            if (wr_en && addr_j <= reg_loop) begin
                regs[addr_j] <= din;
            end
            // prescaler reload one cycle after either pre byte is written
            a_load <= wr_en && (addr_j == reg_a_pre_lo || addr_j == reg_a_pre_hi);
            b_load <= wr_en && (addr_j == reg_b_pre_lo || addr_j == reg_b_pre_hi);
            // any access to the play slot, read or write
            a_play <= cs && addr_j == reg_a_play;
            b_play <= cs && addr_j == reg_b_play;
        end
    end

    // channel A fields
    assign a_pre   = {regs[reg_a_pre_hi][3:0], regs[reg_a_pre_lo]};
    assign a_mode  = pre_mode_e'(regs[reg_a_pre_hi][5:4]);
    assign a_start = {regs[reg_a_addr_hi][0], regs[reg_a_addr_mid], regs[reg_a_addr_lo]};
    assign a_loop  = regs[reg_loop][0];

    // channel B fields
    assign b_pre   = {regs[reg_b_pre_hi][3:0], regs[reg_b_pre_lo]};
    assign b_mode  = pre_mode_e'(regs[reg_b_pre_hi][5:4]);
    assign b_start = {regs[reg_b_addr_hi][0], regs[reg_b_addr_mid], regs[reg_b_addr_lo]};
    assign b_loop  = regs[reg_loop][1];

    // gain nibbles, A in the high half by default
    assign gain_a = gain_a_hi ? regs[reg_gain][7:4] : regs[reg_gain][3:0];
    assign gain_b = gain_a_hi ? regs[reg_gain][3:0] : regs[reg_gain][7:4];

endmodule

// File: logic/pcm_clk_div.sv
// E and Q clock enable generation and half-rate sample tick
`timescale 1ns/1ps

module pcm_clk_div (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic cen_e,
    output logic cen_q,
    output logic smp_tick
);

    // counts cen pulses, four per E/Q period
    logic [1:0] cen_cnt;
    // halves the Q rate
    logic       div2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt  <= 2'd0;
            cen_e    <= 1'b0;
            cen_q    <= 1'b0;
            smp_tick <= 1'b0;
            div2     <= 1'b0;
        end else begin
            if (cen) begin
                cen_cnt <= cen_cnt + 2'd1;
            end
            // Q on the 2nd, E on the 4th cen pulse
            cen_q    <= cen && cen_cnt == 2'd1;
            cen_e    <= cen && cen_cnt == 2'd3;
            // every other Q slot, one tick per 8 cen
            smp_tick <= cen && cen_cnt == 2'd1 && div2;
            if (cen_q) begin
                div2 <= ~div2;
            end
        end
    end

endmodule

// File: logic/pcm_channel.sv
// one playback channel with prescaler, address counter, rom fetch and end/loop handling
`timescale 1ns/1ps

module pcm_channel #(
    parameter logic [pcm_pkg::smp_w-1:0] smp_offset = 7'd64
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        smp_tick,
    input  logic [pcm_pkg::rom_aw-1:0]  start_addr,
    input  logic [pcm_pkg::pre_w-1:0]   pre_val,
    input  pcm_pkg::pre_mode_e          pre_mode,
    input  logic                        loop,
    input  logic                        play,
    input  logic                        load,
    input  logic [7:0]                  rom_dout,
    input  logic                        rom_ok,
    output logic [pcm_pkg::rom_aw-1:0]  rom_addr,
    output logic                        rom_cs,
    output logic [pcm_pkg::smp_w-1:0]   snd
);
    import pcm_pkg::*;

    ch_state_e        state;
    logic             play_l;
    logic             play_rise;
    logic [pre_w-1:0] cnt;
    logic             over;
    logic             nib_mode;
    logic             fetch;
    logic             stall;

    // per-nibble stepping has no carry between fields
    function automatic logic [rom_aw-1:0] next_addr(
        input logic [rom_aw-1:0] a,
        input logic              nib
    );
        logic [rom_aw-1:0] n;
        if (nib) begin
            n[3:0]         = a[3:0] + 4'd1;
            n[7:4]         = a[7:4] + 4'd1;
            n[11:8]        = a[11:8] + 4'd1;
            n[rom_aw-1:12] = a[rom_aw-1:12] + 1'b1;
        end else begin
            n = a + 1'b1;
        end
        return n;
    endfunction

    assign nib_mode  = pre_mode == pre_nibble;
    assign play_rise = play && !play_l;
    assign rom_cs    = state == ch_play;

    // overflow point set by the mode
    always_comb begin
        if (nib_mode) begin
            over = &cnt[pre_w-1:8];
        end else if (pre_mode == pre_full) begin
            over = &cnt;
        end else begin
            over = &cnt[7:0];
        end
    end

    // byte due and rom ready, or due and rom not ready
    assign fetch = smp_tick && over && state == ch_play && rom_ok;
    assign stall = smp_tick && over && state == ch_play && !rom_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ch_idle;
            play_l   <= 1'b0;
            cnt      <= '0;
            rom_addr <= '0;
            snd      <= '0;
        end else begin
            play_l <= play;
            // prescaler freezes at overflow until the rom answers
            if (smp_tick && !stall) begin
                if (over) begin
                    cnt <= pre_val;
                end else if (nib_mode) begin
                    cnt[7:0]       <= cnt[7:0] + 8'd1;
                    cnt[pre_w-1:8] <= cnt[pre_w-1:8] + 4'd1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
            if (fetch) begin
                snd <= rom_dout[6:0] - smp_offset;
                // bit 7 marks the last byte
                if (rom_dout[7]) begin
                    if (loop) begin
                        rom_addr <= start_addr;
                    end else begin
                        state <= ch_idle;
                    end
                end else begin
                    rom_addr <= next_addr(rom_addr, nib_mode);
                end
            end
            if (load) begin
                cnt <= pre_val;
            end
            // restart wins over any step
            if (play_rise) begin
                state    <= ch_play;
                rom_addr <= start_addr;
            end
            // silent while idle
            if (state == ch_idle) begin
                snd <= '0;
            end
        end
    end

endmodule

// File: logic/pcm_mixer.sv
// per-channel gain scaling and registered sum of both channels
`timescale 1ns/1ps

module pcm_mixer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic signed [pcm_pkg::smp_w-1:0]  snd_a,
    input  logic signed [pcm_pkg::smp_w-1:0]  snd_b,
    input  logic [3:0]                        gain_a,
    input  logic [3:0]                        gain_b,
    output logic signed [7:0]                 snd
);
    import pcm_pkg::*;

    // 7b signed x 4b unsigned fits 12b, and so does the sum
    logic signed [11:0] prod_a;
    logic signed [11:0] prod_b;
    logic signed [11:0] mix_sum;
    logic signed [11:0] mix_shr;

    // gains are zero-extended so they stay positive
    assign prod_a  = snd_a * $signed({1'b0, gain_a});
    assign prod_b  = snd_b * $signed({1'b0, gain_b});
    assign mix_sum = prod_a + prod_b;
    // divide by 16, peak magnitude 120
    assign mix_shr = mix_sum >>> 4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd <= '0;
        end else begin
            snd <= mix_shr[7:0];
        end
    end

endmodule

// File: logic/pcm_top.sv
// pcm player top level with registers, clock divider, two channels and mixer
`timescale 1ns/1ps

module pcm_top #(
    parameter bit                        inv_a0     = 1'b0,
    parameter bit                        gain_a_hi  = 1'b1,
    parameter logic [pcm_pkg::smp_w-1:0] smp_offset = 7'd64
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,
    input  logic [3:0]                  addr,
    input  logic [7:0]                  din,
    input  logic                        cs,
    input  logic                        wr_n,
    output logic                        cen_e,
    output logic                        cen_q,
    output logic [pcm_pkg::rom_aw-1:0]  roma_addr,
    output logic                        roma_cs,
    input  logic [7:0]                  roma_dout,
    input  logic                        roma_ok,
    output logic [pcm_pkg::rom_aw-1:0]  romb_addr,
    output logic                        romb_cs,
    input  logic [7:0]                  romb_dout,
    input  logic                        romb_ok,
    output logic [pcm_pkg::smp_w-1:0]   snd_a,
    output logic [pcm_pkg::smp_w-1:0]   snd_b,
    output logic signed [7:0]           snd
);
    import pcm_pkg::*;

    logic [rom_aw-1:0] a_start;
    logic [rom_aw-1:0] b_start;
    logic [pre_w-1:0]  a_pre;
    logic [pre_w-1:0]  b_pre;
    pre_mode_e         a_mode;
    pre_mode_e         b_mode;
    logic              a_loop;
    logic              b_loop;
    logic              a_load;
    logic              b_load;
    logic              a_play;
    logic              b_play;
    logic [3:0]        gain_a;
    logic [3:0]        gain_b;
    logic              smp_tick;

    pcm_regs #(
        .inv_a0    (inv_a0),
        .gain_a_hi (gain_a_hi)
    ) i_pcm_regs (
        .clk     (clk),
        .rst     (rst),
        .addr    (addr),
        .din     (din),
        .cs      (cs),
        .wr_n    (wr_n),
        .a_start (a_start),
        .b_start (b_start),
        .a_pre   (a_pre),
        .b_pre   (b_pre),
        .a_mode  (a_mode),
        .b_mode  (b_mode),
        .a_loop  (a_loop),
        .b_loop  (b_loop),
        .a_load  (a_load),
        .b_load  (b_load),
        .a_play  (a_play),
        .b_play  (b_play),
        .gain_a  (gain_a),
        .gain_b  (gain_b)
    );

    pcm_clk_div i_pcm_clk_div (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .cen_e    (cen_e),
        .cen_q    (cen_q),
        .smp_tick (smp_tick)
    );

    // each channel keeps its own rom port
    pcm_channel #(
        .smp_offset (smp_offset)
    ) i_pcm_channel_a (
        .clk        (clk),
        .rst        (rst),
        .smp_tick   (smp_tick),
        .start_addr (a_start),
        .pre_val    (a_pre),
        .pre_mode   (a_mode),
        .loop       (a_loop),
        .play       (a_play),
        .load       (a_load),
        .rom_dout   (roma_dout),
        .rom_ok     (roma_ok),
        .rom_addr   (roma_addr),
        .rom_cs     (roma_cs),
        .snd        (snd_a)
    );

    pcm_channel #(
        .smp_offset (smp_offset)
    ) i_pcm_channel_b (
        .clk        (clk),
        .rst        (rst),
        .smp_tick   (smp_tick),
        .start_addr (b_start),
        .pre_val    (b_pre),
        .pre_mode   (b_mode),
        .loop       (b_loop),
        .play       (b_play),
        .load       (b_load),
        .rom_dout   (romb_dout),
        .rom_ok     (romb_ok),
        .rom_addr   (romb_addr),
        .rom_cs     (romb_cs),
        .snd        (snd_b)
    );

    pcm_mixer i_pcm_mixer (
        .clk    (clk),
        .rst    (rst),
        .snd_a  (snd_a),
        .snd_b  (snd_b),
        .gain_a (gain_a),
        .gain_b (gain_b),
        .snd    (snd)
    );

endmodule

// File: tb/pcm_tb.sv
// pcm player testbench with clock, reset, rom models, lfsr, compare tasks and directed tests
`timescale 1ns/1ps

module pcm_tb;
    import pcm_pkg::*;

    // start addresses used by the tests
    localparam logic [rom_aw-1:0] a_base = 17'h00100;
    localparam logic [rom_aw-1:0] b_base = 17'h00010;

    logic              clk;
    logic              rst;
    logic              cen;
    logic [3:0]        addr;
    logic [7:0]        din;
    logic              cs;
    logic              wr_n;
    logic              cen_e;
    logic              cen_q;
    logic [rom_aw-1:0] roma_addr;
    logic              roma_cs;
    logic [7:0]        roma_dout;
    logic              roma_ok;
    logic [rom_aw-1:0] romb_addr;
    logic              romb_cs;
    logic [7:0]        romb_dout;
    logic              romb_ok;
    logic [smp_w-1:0]  snd_a;
    logic [smp_w-1:0]  snd_b;
    logic signed [7:0] snd;

    // sample roms, only the low 12 address bits decoded
    logic [7:0]  rom_a [0:4095];
    logic [7:0]  rom_b [0:4095];
    logic [31:0] lfsr;
    int          checks;
    int          value_errors;
    int          other_errors;
    int          b_wraps;

    assign roma_dout = rom_a[roma_addr[11:0]];
    assign romb_dout = rom_b[romb_addr[11:0]];

    pcm_top i_pcm_top (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .addr      (addr),
        .din       (din),
        .cs        (cs),
        .wr_n      (wr_n),
        .cen_e     (cen_e),
        .cen_q     (cen_q),
        .roma_addr (roma_addr),
        .roma_cs   (roma_cs),
        .roma_dout (roma_dout),
        .roma_ok   (roma_ok),
        .romb_addr (romb_addr),
        .romb_cs   (romb_cs),
        .romb_dout (romb_dout),
        .romb_ok   (romb_ok),
        .snd_a     (snd_a),
        .snd_b     (snd_b),
        .snd       (snd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois form, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one step per bit taken
    task automatic random_byte(output logic [7:0] b);
        int i;
        b = 8'd0;
        for (i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic fill_roms;
        logic [7:0] b;
        int         i;
        lfsr = 32'hb9bb;
        for (i = 0; i < 4096; i++) begin
            random_byte(b);
            rom_a[i] = {1'b0, b[6:0]};
            random_byte(b);
            rom_b[i] = {1'b0, b[6:0]};
        end
        // end markers, A after six bytes, B on its fourth nibble step
        rom_a[12'h105][7] = 1'b1;
        rom_b[12'h343][7] = 1'b1;
    endtask

    // low seven bits less the 64 offset, wraps in 7 bits
    function automatic logic [smp_w-1:0] sample_of_byte(input logic [7:0] b);
        return b[6:0] - 7'd64;
    endfunction

    // every nibble field +1 on its own, top field too
    function automatic logic [rom_aw-1:0] nibble_step(input logic [rom_aw-1:0] a);
        logic [rom_aw-1:0] r;
        int                k;
        r = a;
        for (k = 0; k < 3; k++) begin
            r[4*k +: 4] = a[4*k +: 4] + 4'd1;
        end
        r[rom_aw-1:12] = a[rom_aw-1:12] + 5'd1;
        return r;
    endfunction

    function automatic logic signed [7:0] mix_of(input logic signed [smp_w-1:0] sa,
                                                 input logic signed [smp_w-1:0] sb,
                                                 input logic [3:0] ga,
                                                 input logic [3:0] gb);
        int total;
        total = int'(sa) * int'(ga) + int'(sb) * int'(gb);
        total = total >>> 4;
        return total[7:0];
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input reg_addr_e a, input logic [7:0] d);
        addr = a;
        din  = d;
        cs   = 1'b1;
        wr_n = 1'b0;
        next_cycle();
        cs   = 1'b0;
        wr_n = 1'b1;
    endtask

    task automatic note_failure(input string msg);
        other_errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_sample(input string name, input logic [smp_w-1:0] got,
                                input logic [smp_w-1:0] want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, name,
                     $signed(got), $signed(want));
        end
    endtask

    task automatic check_mix(input string name, input logic signed [7:0] got,
                             input logic signed [7:0] want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_addr(input string name, input logic [rom_aw-1:0] got,
                              input logic [rom_aw-1:0] want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic test_reset_state;
        check_flag("cen_e", cen_e, 1'b0);
        check_flag("cen_q", cen_q, 1'b0);
        check_flag("roma_cs", roma_cs, 1'b0);
        check_flag("romb_cs", romb_cs, 1'b0);
        check_sample("snd_a", snd_a, '0);
        check_sample("snd_b", snd_b, '0);
        check_mix("snd", snd, '0);
    endtask

    task automatic test_clock_enables;
        int cyc;
        int last_q;
        int last_e;
        int nq;
        int ne;
        last_q = -1;
        last_e = -1;
        nq = 0;
        ne = 0;
        for (cyc = 0; cyc < 64; cyc++) begin
            next_cycle();
            if (cen_q && cen_e) begin
                note_failure("cen_e and cen_q high in the same cycle");
            end
            if (cen_q) begin
                if (last_q >= 0 && cyc - last_q != 4) begin
                    note_failure("cen_q period is not 4 cycles");
                end
                last_q = cyc;
                nq++;
            end
            if (cen_e) begin
                if (last_q >= 0 && cyc - last_q != 2) begin
                    note_failure("cen_e does not follow cen_q by 2 cycles");
                end
                if (last_e >= 0 && cyc - last_e != 4) begin
                    note_failure("cen_e period is not 4 cycles");
                end
                last_e = cyc;
                ne++;
            end
        end
        if (nq != 16 || ne != 16) begin
            note_failure("wrong number of cen_e or cen_q pulses in 64 cycles");
        end
    endtask

    task automatic test_one_shot_a;
        logic [rom_aw-1:0] prev;
        logic [7:0]        b;
        int                cyc;
        int                last_step;
        int                steps;
        logic              done;
        // pre_val 4094 in full mode, one byte per two ticks
        write_reg(reg_a_pre_lo, 8'hfe);
        write_reg(reg_a_pre_hi, {2'b00, pre_full, 4'hf});
        write_reg(reg_a_addr_lo, a_base[7:0]);
        write_reg(reg_a_addr_mid, a_base[15:8]);
        write_reg(reg_a_addr_hi, {7'd0, a_base[16]});
        write_reg(reg_a_play, 8'h00);
        cyc = 0;
        while (!roma_cs && cyc < 8) begin
            next_cycle();
            cyc++;
        end
        if (!roma_cs) begin
            note_failure("channel A did not start after the play access");
        end
        check_addr("roma_addr", roma_addr, a_base);
        prev = roma_addr;
        last_step = -1;
        steps = 0;
        done = 1'b0;
        for (cyc = 0; cyc < 400 && !done; cyc++) begin
            next_cycle();
            if (!roma_cs || roma_addr != prev) begin
                b = rom_a[prev[11:0]];
                check_sample("snd_a", snd_a, sample_of_byte(b));
                if (last_step >= 0 && cyc - last_step != 16) begin
                    note_failure("channel A byte interval is not 16 cycles");
                end
                last_step = cyc;
                if (!roma_cs) begin
                    // end marker byte was the last fetch
                    check_flag("end byte bit 7", b[7], 1'b1);
                    done = 1'b1;
                end else begin
                    check_addr("roma_addr", roma_addr, prev + 17'd1);
                    prev = roma_addr;
                    steps++;
                end
            end
        end
        if (!done) begin
            note_failure("channel A never reached its end marker");
        end
        if (steps != 5) begin
            note_failure("channel A played the wrong number of bytes");
        end
        next_cycle();
        check_flag("roma_cs", roma_cs, 1'b0);
        check_sample("snd_a", snd_a, '0);
    endtask

    // follows B through n address steps, loop bit assumed set
    task automatic track_b_steps(input int n);
        logic [rom_aw-1:0] prev;
        logic [rom_aw-1:0] want;
        logic [7:0]        b;
        int                cyc;
        int                idle;
        int                last_step;
        int                seen;
        prev = romb_addr;
        cyc = 0;
        idle = 0;
        last_step = -1;
        seen = 0;
        while (seen < n && idle < 40) begin
            next_cycle();
            cyc++;
            idle++;
            check_flag("romb_cs", romb_cs, 1'b1);
            if (romb_addr != prev) begin
                b = rom_b[prev[11:0]];
                want = b[7] ? b_base : nibble_step(prev);
                if (b[7]) begin
                    b_wraps++;
                end
                check_sample("snd_b", snd_b, sample_of_byte(b));
                check_addr("romb_addr", romb_addr, want);
                if (last_step >= 0 && cyc - last_step != 16) begin
                    note_failure("channel B byte interval is not 16 cycles");
                end
                last_step = cyc;
                prev = romb_addr;
                seen++;
                idle = 0;
            end
        end
        if (seen < n) begin
            note_failure("channel B stopped stepping its address");
        end
    endtask

    task automatic test_loop_nibble_b;
        int cyc;
        // high nibble E, overflow every second tick
        write_reg(reg_b_pre_lo, 8'h00);
        write_reg(reg_b_pre_hi, {2'b00, pre_nibble, 4'he});
        write_reg(reg_b_addr_lo, b_base[7:0]);
        write_reg(reg_b_addr_mid, b_base[15:8]);
        write_reg(reg_b_addr_hi, {7'd0, b_base[16]});
        write_reg(reg_loop, 8'h02);
        write_reg(reg_b_play, 8'h00);
        cyc = 0;
        while (!romb_cs && cyc < 8) begin
            next_cycle();
            cyc++;
        end
        if (!romb_cs) begin
            note_failure("channel B did not start after the play access");
        end
        check_addr("romb_addr", romb_addr, b_base);
        b_wraps = 0;
        // four bytes to the marker, then two more after the wrap
        track_b_steps(6);
        if (b_wraps == 0) begin
            note_failure("channel B never returned to its start address");
        end
    endtask

    task automatic test_stall_b;
        logic [rom_aw-1:0] held_addr;
        logic [smp_w-1:0]  held_snd;
        held_addr = romb_addr;
        held_snd = snd_b;
        romb_ok = 1'b0;
        // six ticks, three overflow points
        repeat (48) begin
            next_cycle();
            check_addr("romb_addr", romb_addr, held_addr);
            check_sample("snd_b", snd_b, held_snd);
        end
        romb_ok = 1'b1;
        track_b_steps(2);
    endtask

    task automatic test_mixer;
        logic signed [smp_w-1:0] prev_a;
        logic signed [smp_w-1:0] prev_b;
        int                      cyc;
        int                      both;
        write_reg(reg_loop, 8'h03);
        write_reg(reg_gain, 8'ha5);
        write_reg(reg_a_play, 8'h00);
        cyc = 0;
        while (!roma_cs && cyc < 8) begin
            next_cycle();
            cyc++;
        end
        if (!roma_cs) begin
            note_failure("channel A did not restart for the mixer test");
        end
        prev_a = snd_a;
        prev_b = snd_b;
        both = 0;
        for (cyc = 0; cyc < 200; cyc++) begin
            next_cycle();
            // gain A from the high nibble
            check_mix("snd", snd, mix_of(prev_a, prev_b, 4'ha, 4'h5));
            if (prev_a != 0 && prev_b != 0) begin
                both++;
            end
            prev_a = snd_a;
            prev_b = snd_b;
        end
        if (both == 0) begin
            note_failure("mixer never saw both channels active");
        end
    endtask

    initial begin
        rst = 1'b1;
        cen = 1'b1;
        addr = 4'd0;
        din = 8'd0;
        cs = 1'b0;
        wr_n = 1'b1;
        roma_ok = 1'b1;
        romb_ok = 1'b1;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        b_wraps = 0;
        fill_roms();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_clock_enables();
        test_one_shot_a();
        test_loop_nibble_b();
        test_stall_b();
        test_mixer();
        $display("checks %0d, value errors %0d, other failures %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/pcm_pkg.sv
logic/pcm_regs.sv
logic/pcm_clk_div.sv
logic/pcm_channel.sv
logic/pcm_mixer.sv
logic/pcm_top.sv
tb/pcm_tb.sv

// File: Makefile
LOG = sim.log

sim:
	verilator --binary --timing -Wno-fatal --top-module pcm_tb -f sources.f -o pcm_sim
	./obj_dir/pcm_sim > $(LOG)
	cat $(LOG)
	! grep -qF '** FAIL **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
